//--- source/cache_pkg.sv
/* instruction cache definitions
   address field widths, cache geometry and the tag entry type */

package cache_pkg;

   // front-end address and word size
   localparam int ADDR_W     = 16;   // byte address
   localparam int DATA_W     = 32;

   // address split: tag | index | word offset | byte offset
   localparam int BYTE_OFF_W = 2;
   localparam int WORD_OFF_W = 2;
   localparam int INDEX_W    = 4;
   localparam int TAG_W      = ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;

   // bit positions of the fields inside a byte address
   localparam int WORD_OFF_LSB = BYTE_OFF_W;
   localparam int INDEX_LSB    = BYTE_OFF_W + WORD_OFF_W;
   localparam int TAG_LSB      = INDEX_LSB + INDEX_W;

   // geometry
   localparam int LINE_WORDS  = 1 << WORD_OFF_W;   // also the beats per refill
   localparam int N_LINES     = 1 << INDEX_W;
   localparam int LINE_ADDR_W = TAG_W + INDEX_W;   // address of a whole line

   // data array is addressed by index and word offset together
   localparam int DATA_AW    = INDEX_W + WORD_OFF_W;
   localparam int DATA_DEPTH = N_LINES * LINE_WORDS;

   typedef logic [TAG_W-1:0]       tag_t;
   typedef logic [INDEX_W-1:0]     index_t;
   typedef logic [WORD_OFF_W-1:0]  word_off_t;
   typedef logic [DATA_W-1:0]      word_t;
   typedef logic [LINE_ADDR_W-1:0] line_addr_t;   // {tag, index}

   // one entry of the tag array
   typedef struct packed {
      logic valid;   // cleared by reset, set when the line is refilled
      tag_t tag;
   } tag_entry_t;

endpackage

//--- source/refill_if.sv
/* cache controller to line refill link
   refill request from the controller, refill words back from the refill block */

`timescale 1ns/10ps

interface refill_if;
   import cache_pkg::*;

   logic       replace_valid;   // refill request, held until replace is seen
   line_addr_t replace_addr;    // line to fetch
   logic       replace;         // refill in progress
   logic       read_valid;      // one refill word this cycle
   word_off_t  read_addr;       // word offset of that word
   word_t      read_rdata;

   modport ctrl (
      output replace_valid,
      output replace_addr,
      input  replace,
      input  read_valid,
      input  read_addr,
      input  read_rdata
   );

   modport refill (
      input  replace_valid,
      input  replace_addr,
      output replace,
      output read_valid,
      output read_addr,
      output read_rdata
   );

endinterface

//--- source/cache_array.sv
/* synchronous-read storage array
   one write port and one registered read port, payload type set by parameter */

`timescale 1ns/10ps

module cache_array #(
   parameter type entry_t = cache_pkg::word_t,
   parameter int  DEPTH   = cache_pkg::N_LINES
) (
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  logic                     we_i,
   input  logic [$clog2(DEPTH)-1:0] waddr_i,
   input  logic [$clog2(DEPTH)-1:0] raddr_i,
   input  entry_t                   wdata_i,
   output entry_t                   rdata_o
);

   entry_t mem_q [DEPTH];

   // a cleared tag entry has valid low, so reset empties the cache
   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem_q[i] <= '0;
         end
         rdata_o <= '0;
      end else begin
         if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
         end
         // read sees the old entry when both ports hit the same address
         rdata_o <= mem_q[raddr_i];   // data one cycle after the address
      end
   end

endmodule

//--- source/line_refill.sv
/* line refill engine
   fetches one cache line from the memory bus, one word per acknowledged beat,
   and streams each word to the controller with its offset */

`timescale 1ns/10ps

module line_refill (
   input  logic                         clk_i,
   input  logic                         reset_i,
   refill_if.refill                     rf,
   output logic                         be_valid_o,
   output logic [cache_pkg::ADDR_W-1:0] be_addr_o,
   input  logic                         be_ack_i,
   input  cache_pkg::word_t             be_rdata_i
);
   import cache_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_HANDSHAKE,   // bus beats, one word per ack
      ST_END          // one cycle after the last word
   } state_t;

   state_t    state_q;
   word_off_t beat_q;      // word offset of the current beat
   logic      beat_done;
   logic      last_beat;

   assign beat_done = (state_q == ST_HANDSHAKE) && be_ack_i;
   assign last_beat = (beat_q == word_off_t'(LINE_WORDS - 1));

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         state_q <= ST_IDLE;
         beat_q  <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               beat_q <= '0;   // every line starts at its base word
               if (rf.replace_valid) begin
                  state_q <= ST_HANDSHAKE;
               end
            end
            ST_HANDSHAKE: begin
               if (be_ack_i) begin
                  beat_q <= beat_q + 1'b1;
                  if (last_beat) begin
                     state_q <= ST_END;
                  end
               end
            end
            ST_END: begin
               state_q <= ST_IDLE;
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // valid and address only change on an ack, so both hold while the bus waits
   assign be_valid_o = (state_q == ST_HANDSHAKE);
   assign be_addr_o  = {rf.replace_addr, beat_q, {BYTE_OFF_W{1'b0}}};

   // busy from acceptance up to and including the end cycle
   assign rf.replace = (state_q != ST_IDLE);

   // bus words go straight through, tagged with the beat offset
   assign rf.read_valid = beat_done;
   assign rf.read_addr  = beat_q;
   assign rf.read_rdata = be_rdata_i;

endmodule

//--- source/cache_ctrl.sv
/* instruction cache controller
   request acceptance, tag compare and hit response, miss refill with array
   writes, then tag update and replay of the missed request */

`timescale 1ns/10ps

module cache_ctrl (
   input  logic                          clk_i,
   input  logic                          reset_i,
   input  logic                          req_valid_i,
   input  logic [cache_pkg::ADDR_W-1:0]  req_addr_i,
   output logic                          req_ready_o,
   output logic                          rsp_valid_o,
   output cache_pkg::word_t              rsp_rdata_o,
   refill_if.ctrl                        rf,
   output logic                          tag_we_o,
   output cache_pkg::index_t             tag_waddr_o,
   output cache_pkg::index_t             tag_raddr_o,
   output cache_pkg::tag_entry_t         tag_wdata_o,
   input  cache_pkg::tag_entry_t         tag_rdata_i,
   output logic                          data_we_o,
   output logic [cache_pkg::DATA_AW-1:0] data_waddr_o,
   output logic [cache_pkg::DATA_AW-1:0] data_raddr_o,
   output cache_pkg::word_t              data_wdata_o,
   input  cache_pkg::word_t              data_rdata_i
);
   import cache_pkg::*;

   typedef enum logic [2:0] {
      ST_RUN,      // accepting requests, lookups in flight
      ST_REQ,      // refill requested, waiting for the refill block to start
      ST_FILL,     // refill words arriving
      ST_TAG,      // refill end cycle, tag entry written
      ST_REPLAY    // arrays read again with the held address
   } state_t;

   state_t    state_q;
   logic      lookup_q;   // a lookup is in progress this cycle
   tag_t      tag_q;      // fields of the held request
   index_t    idx_q;
   word_off_t off_q;

   tag_t      req_tag;
   index_t    req_idx;
   word_off_t req_off;
   logic      accept;
   logic      tag_match;
   logic      miss;
   logic      last_word;

   // field split of the incoming byte address, low byte bits dropped
   assign req_tag = req_addr_i[TAG_LSB +: TAG_W];
   assign req_idx = req_addr_i[INDEX_LSB +: INDEX_W];
   assign req_off = req_addr_i[WORD_OFF_LSB +: WORD_OFF_W];

   assign accept    = req_valid_i && req_ready_o;
   assign tag_match = tag_rdata_i.valid && (tag_rdata_i.tag == tag_q);
   assign miss      = lookup_q && !tag_match;
   assign last_word = rf.read_valid && (rf.read_addr == word_off_t'(LINE_WORDS - 1));

   // a miss drops ready in its own lookup cycle, so nothing else gets in
   assign req_ready_o = (state_q == ST_RUN) && !miss;
   assign rsp_valid_o = lookup_q && tag_match;
   assign rsp_rdata_o = data_rdata_i;

   always_ff @(posedge clk_i or posedge reset_i) begin
      if (reset_i) begin
         state_q  <= ST_RUN;
         lookup_q <= 1'b0;
      end else begin
         lookup_q <= 1'b0;
         case (state_q)
            ST_RUN: begin
               lookup_q <= accept;
               if (miss) begin
                  state_q <= ST_REQ;
               end
            end
            ST_REQ: begin
               if (rf.replace) begin
                  state_q <= ST_FILL;
               end
            end
            ST_FILL: begin
               if (last_word) begin
                  state_q <= ST_TAG;   // refill block enters its end cycle
               end
            end
            ST_TAG: begin
               state_q <= ST_REPLAY;
            end
            ST_REPLAY: begin
               state_q  <= ST_RUN;
               lookup_q <= 1'b1;       // replayed lookup now hits
            end
            default: begin
               state_q <= ST_RUN;
            end
         endcase
      end
   end

   // held request, kept through the whole miss sequence
   always_ff @(posedge clk_i) begin
      if (accept) begin
         tag_q <= req_tag;
         idx_q <= req_idx;
         off_q <= req_off;
      end
   end

   // refill request stays up until the refill block reports busy
   assign rf.replace_valid = (state_q == ST_REQ);
   assign rf.replace_addr  = {tag_q, idx_q};

   // arrays read the incoming address, except during replay
   assign tag_raddr_o  = (state_q == ST_REPLAY) ? idx_q : req_idx;
   assign data_raddr_o = (state_q == ST_REPLAY) ? {idx_q, off_q} : {req_idx, req_off};

   // each refill word lands at its line and offset
   assign data_we_o    = rf.read_valid;
   assign data_waddr_o = {idx_q, rf.read_addr};
   assign data_wdata_o = rf.read_rdata;

   // line marked valid only once all its words are in place
   assign tag_we_o    = (state_q == ST_TAG);
   assign tag_waddr_o = idx_q;
   assign tag_wdata_o = '{valid: 1'b1, tag: tag_q};

endmodule

//--- source/icache_top.sv
/* direct-mapped read-only instruction cache
   front-end request port, tag and data arrays, refill over the memory bus */

`timescale 1ns/10ps

module icache_top (
   input  logic                         clk_i,
   input  logic                         reset_i,
   // front end
   input  logic                         req_valid_i,
   output logic                         req_ready_o,
   input  logic [cache_pkg::ADDR_W-1:0] req_addr_i,
   output logic                         rsp_valid_o,
   output cache_pkg::word_t             rsp_rdata_o,
   // memory bus
   output logic                         be_valid_o,
   output logic [cache_pkg::ADDR_W-1:0] be_addr_o,
   input  logic                         be_ack_i,
   input  cache_pkg::word_t             be_rdata_i
);
   import cache_pkg::*;

   logic               tag_we;
   index_t             tag_waddr;
   index_t             tag_raddr;
   tag_entry_t         tag_wdata;
   tag_entry_t         tag_rdata;

   logic               data_we;
   logic [DATA_AW-1:0] data_waddr;
   logic [DATA_AW-1:0] data_raddr;
   word_t              data_wdata;
   word_t              data_rdata;

   refill_if u_rf ();

   cache_ctrl u_ctrl (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .req_valid_i  (req_valid_i),
      .req_addr_i   (req_addr_i),
      .req_ready_o  (req_ready_o),
      .rsp_valid_o  (rsp_valid_o),
      .rsp_rdata_o  (rsp_rdata_o),
      .rf           (u_rf.ctrl),
      .tag_we_o     (tag_we),
      .tag_waddr_o  (tag_waddr),
      .tag_raddr_o  (tag_raddr),
      .tag_wdata_o  (tag_wdata),
      .tag_rdata_i  (tag_rdata),
      .data_we_o    (data_we),
      .data_waddr_o (data_waddr),
      .data_raddr_o (data_raddr),
      .data_wdata_o (data_wdata),
      .data_rdata_i (data_rdata)
   );

   line_refill u_refill (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .rf         (u_rf.refill),
      .be_valid_o (be_valid_o),
      .be_addr_o  (be_addr_o),
      .be_ack_i   (be_ack_i),
      .be_rdata_i (be_rdata_i)
   );

   cache_array #(.entry_t(tag_entry_t), .DEPTH(N_LINES)) u_tags (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .we_i    (tag_we),
      .waddr_i (tag_waddr),
      .raddr_i (tag_raddr),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata)
   );

   cache_array #(.entry_t(word_t), .DEPTH(DATA_DEPTH)) u_data (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .we_i    (data_we),
      .waddr_i (data_waddr),
      .raddr_i (data_raddr),
      .wdata_i (data_wdata),
      .rdata_o (data_rdata)
   );

endmodule

//--- tests/icache_chk.sv
/* protocol checks for the instruction cache
   memory bus beat stability, response pairing and stall behavior */

`timescale 1ns/10ps

module icache_chk (
   input logic                         clk_i,
   input logic                         reset_i,
   input logic                         req_valid_i,
   input logic                         req_ready_o,
   input logic                         rsp_valid_o,
   input logic                         be_valid_o,
   input logic [cache_pkg::ADDR_W-1:0] be_addr_o,
   input logic                         be_ack_i
);

   // a beat keeps valid and address until the slave acks it
   a_be_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      be_valid_o && !be_ack_i |=> be_valid_o && $stable(be_addr_o))
      else $error("memory bus beat changed before its ack");

   // a second response in a row needs a request taken in the cycle before
   a_rsp_pair: assert property (@(posedge clk_i) disable iff (reset_i)
      rsp_valid_o && $past(rsp_valid_o) |-> $past(req_valid_i && req_ready_o))
      else $error("response in back-to-back cycles without a new request");

   // the port stays closed through a miss and reopens only with its response
   a_stall_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(req_ready_o) |-> rsp_valid_o)
      else $error("req_ready_o rose without the response of the stalled request");

endmodule

bind icache_top icache_chk u_chk (
   .clk_i       (clk_i),
   .reset_i     (reset_i),
   .req_valid_i (req_valid_i),
   .req_ready_o (req_ready_o),
   .rsp_valid_o (rsp_valid_o),
   .be_valid_o  (be_valid_o),
   .be_addr_o   (be_addr_o),
   .be_ack_i    (be_ack_i)
);

//--- tests/icache_tb.sv
/* instruction cache testbench
   drives the front end, models the memory bus and checks every response */

`timescale 1ns/10ps

module icache_tb;
   import cache_pkg::*;

   localparam int CLK_HALF   = 5;
   localparam int WAIT_LIMIT = 200;   // cycles allowed for any single wait
   localparam int N_SWEEP    = 300;

   logic              clk_i;
   logic              reset_i;
   logic              req_valid_i;
   logic              req_ready_o;
   logic [ADDR_W-1:0] req_addr_i;
   logic              rsp_valid_o;
   word_t             rsp_rdata_o;
   logic              be_valid_o;
   logic [ADDR_W-1:0] be_addr_o;
   logic              be_ack_i;
   word_t             be_rdata_i;

   logic [ADDR_W-1:0] pending [$];   // accepted addresses with the oldest at the front
   int                err_count;
   int                check_count;
   int                rsp_count;
   int                beat_count;
   int                beat_in_line;
   int                ack_delay;
   int                model_misses;
   logic [ADDR_W-1:0] line_base;     // base of the line last seen on the bus
   logic              model_valid [N_LINES];
   tag_t              model_tag [N_LINES];

   icache_top UUT (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .req_valid_i (req_valid_i),
      .req_ready_o (req_ready_o),
      .req_addr_i  (req_addr_i),
      .rsp_valid_o (rsp_valid_o),
      .rsp_rdata_o (rsp_rdata_o),
      .be_valid_o  (be_valid_o),
      .be_addr_o   (be_addr_o),
      .be_ack_i    (be_ack_i),
      .be_rdata_i  (be_rdata_i)
   );

   // memory contents as a function of the byte address
   function automatic word_t mem_word(input logic [ADDR_W-1:0] addr);
      word_t wa;
      wa = word_t'(addr >> BYTE_OFF_W);
      return (wa ^ 32'hA5C3_0000) + (wa << 8);
   endfunction

   function automatic logic [ADDR_W-1:0] line_of(input logic [ADDR_W-1:0] addr);
      return {addr[ADDR_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
   endfunction

   // direct-mapped tag table that counts the misses the DUT should take
   function automatic void model_lookup(input logic [ADDR_W-1:0] addr);
      index_t idx;
      tag_t   tag;
      idx = addr[INDEX_LSB +: INDEX_W];
      tag = addr[TAG_LSB +: TAG_W];
      if (!model_valid[idx] || model_tag[idx] !== tag) begin
         model_misses++;
         model_valid[idx] = 1'b1;
         model_tag[idx]   = tag;
      end
   endfunction

   task automatic finish_run();
      $display("checks: %0d, responses: %0d, bus beats: %0d, errors: %0d",
               check_count, rsp_count, beat_count, err_count);
      if (err_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   endtask

   task automatic abort_wait(input string what);
      err_count++;
      $display("timeout at %0t while waiting for %s", $time, what);
      finish_run();
   endtask

   task automatic end_test(input string name, input int err_before);
      $display("test %s: %s", name, (err_count == err_before) ? "passed" : "failed");
   endtask

   // 8-cycle reset that also forgets all pending requests and resident lines
   task automatic apply_reset();
      reset_i = 1'b1;
      repeat (8) @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      pending.delete();
      for (int i = 0; i < N_LINES; i++) begin
         model_valid[i] = 1'b0;
      end
   endtask

   // present one request and return at the drive point after its acceptance
   task automatic issue_read(input logic [ADDR_W-1:0] addr, output int stalls);
      int n;
      n = 0;
      req_valid_i = 1'b1;
      req_addr_i  = addr;
      @(negedge clk_i);
      while (!req_ready_o) begin
         n++;
         if (n > WAIT_LIMIT) begin
            abort_wait("request acceptance");
         end
         @(negedge clk_i);
      end
      pending.push_back(addr);
      model_lookup(addr);
      stalls = n;
      @(posedge clk_i);
      #1;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (pending.size() != 0) begin
         n++;
         if (n > WAIT_LIMIT) begin
            abort_wait("outstanding responses");
         end
         @(posedge clk_i);
         #1;
      end
   endtask

   initial begin
      clk_i = 1'b0;
      forever #CLK_HALF clk_i = ~clk_i;
   end

   // memory bus slave that acks each beat after 0 to 3 idle cycles
   initial begin
      be_ack_i   = 1'b0;
      be_rdata_i = '0;
      ack_delay  = -1;
      forever begin
         @(posedge clk_i);
         #1;
         be_ack_i   = 1'b0;
         be_rdata_i = '0;
         if (!be_valid_o || reset_i) begin
            ack_delay = -1;
         end else begin
            if (ack_delay < 0) begin
               ack_delay = $urandom_range(3, 0);
            end
            if (ack_delay == 0) begin
               be_ack_i   = 1'b1;
               be_rdata_i = mem_word(be_addr_o);
               ack_delay  = -1;
            end else begin
               ack_delay--;
            end
         end
      end
   end

   // compares responses and follows bus beats mid-cycle where all is stable
   initial begin
      logic [ADDR_W-1:0] exp_addr;
      word_t             exp_word;
      forever begin
         @(negedge clk_i);
         if (rsp_valid_o) begin
            rsp_count++;
            if (pending.size() == 0) begin
               err_count++;
               $display("response at %0t with no request pending", $time);
            end else begin
               exp_addr = pending.pop_front();
               exp_word = mem_word(exp_addr);
               check_count++;
               if (rsp_rdata_o !== exp_word) begin
                  err_count++;
                  $display("Fail at %0t: rsp_rdata_o (addr %h) expected %h got %h",
                           $time, exp_addr, exp_word, rsp_rdata_o);
               end
            end
         end
         if (reset_i) begin
            beat_in_line = 0;
         end else if (be_valid_o && be_ack_i) begin
            if (beat_in_line == 0) begin
               line_base = line_of(be_addr_o);
            end
            check_count++;
            if (be_addr_o !== line_base + ADDR_W'(beat_in_line * 4)) begin
               err_count++;
               $display("Fail at %0t: be_addr_o expected %h got %h",
                        $time, line_base + ADDR_W'(beat_in_line * 4), be_addr_o);
            end
            beat_count++;
            beat_in_line = (beat_in_line + 1) % LINE_WORDS;
         end
      end
   end

   initial begin
      int                stalls;
      int                err0;
      int                beats0;
      int                rsp0;
      int                miss0;
      int                n;
      logic [31:0]       rnd;
      logic [ADDR_W-1:0] addr;
      logic [ADDR_W-1:0] addr_a;
      logic [ADDR_W-1:0] addr_b;
      void'($urandom(44));
      reset_i      = 1'b1;
      req_valid_i  = 1'b0;
      req_addr_i   = '0;
      err_count    = 0;
      check_count  = 0;
      rsp_count    = 0;
      beat_count   = 0;
      beat_in_line = 0;
      model_misses = 0;
      line_base    = '0;
      apply_reset();

      // cold miss then hits in the same line
      err0   = err_count;
      beats0 = beat_count;
      addr_a = 16'h0148;
      issue_read(addr_a, stalls);
      req_valid_i = 1'b0;
      wait_drain();
      check_count += 2;
      if (beat_count - beats0 != LINE_WORDS) begin
         err_count++;
         $display("Fail at %0t: be_ack_i beats expected %0d got %0d",
                  $time, LINE_WORDS, beat_count - beats0);
      end
      if (line_base !== line_of(addr_a)) begin
         err_count++;
         $display("Fail at %0t: be_addr_o line base expected %h got %h",
                  $time, line_of(addr_a), line_base);
      end
      beats0 = beat_count;
      issue_read(addr_a ^ 16'h000C, stalls);
      issue_read(addr_a, stalls);
      req_valid_i = 1'b0;
      wait_drain();
      check_count++;
      if (beat_count != beats0) begin
         err_count++;
         $display("bus traffic on a hit: %0d beats at %0t", beat_count - beats0, $time);
      end
      end_test("1 cold miss then hit", err0);

      // back-to-back hits over the resident line
      err0   = err_count;
      beats0 = beat_count;
      rsp0   = rsp_count;
      for (int w = 0; w < LINE_WORDS; w++) begin
         issue_read(line_of(addr_a) | ADDR_W'(w * 4), stalls);
         check_count++;
         if (stalls != 0) begin
            err_count++;
            $display("Fail at %0t: req_ready_o expected 1 got 0", $time);
         end
      end
      req_valid_i = 1'b0;
      check_count += 2;
      if (rsp_count - rsp0 != LINE_WORDS - 1) begin
         err_count++;
         $display("Fail at %0t: rsp_valid_o count expected %0d got %0d",
                  $time, LINE_WORDS - 1, rsp_count - rsp0);
      end
      @(posedge clk_i);
      #1;
      if (rsp_count - rsp0 != LINE_WORDS) begin
         err_count++;
         $display("Fail at %0t: rsp_valid_o count expected %0d got %0d",
                  $time, LINE_WORDS, rsp_count - rsp0);
      end
      wait_drain();
      check_count++;
      if (beat_count != beats0) begin
         err_count++;
         $display("bus traffic during back-to-back hits at %0t", $time);
      end
      end_test("2 back-to-back hits", err0);

      // same index and different tags so each read evicts the other
      err0   = err_count;
      addr_a = 16'h1234;
      addr_b = 16'h5638;
      for (int r = 0; r < 4; r++) begin
         addr   = (r % 2 == 0) ? addr_a : addr_b;
         beats0 = beat_count;
         issue_read(addr, stalls);
         req_valid_i = 1'b0;
         wait_drain();
         check_count += 2;
         if (beat_count - beats0 != LINE_WORDS) begin
            err_count++;
            $display("Fail at %0t: be_ack_i beats expected %0d got %0d",
                     $time, LINE_WORDS, beat_count - beats0);
         end
         if (line_base !== line_of(addr)) begin
            err_count++;
            $display("Fail at %0t: be_addr_o line base expected %h got %h",
                     $time, line_of(addr), line_base);
         end
      end
      end_test("3 conflict eviction", err0);

      // random sweep over four tags with idle gaps now and then
      err0   = err_count;
      beats0 = beat_count;
      rsp0   = rsp_count;
      miss0  = model_misses;
      for (int i = 0; i < N_SWEEP; i++) begin
         rnd  = $urandom;
         addr = rnd[ADDR_W-1:0] & 16'h03FF;
         issue_read(addr, stalls);
         if ($urandom_range(3, 0) == 0) begin
            req_valid_i = 1'b0;
            @(posedge clk_i);
            #1;
         end
      end
      req_valid_i = 1'b0;
      wait_drain();
      check_count += 2;
      if (beat_count - beats0 != LINE_WORDS * (model_misses - miss0)) begin
         err_count++;
         $display("Fail at %0t: be_ack_i beats expected %0d got %0d",
                  $time, LINE_WORDS * (model_misses - miss0), beat_count - beats0);
      end
      if (rsp_count - rsp0 != N_SWEEP) begin
         err_count++;
         $display("Fail at %0t: rsp_valid_o count expected %0d got %0d",
                  $time, N_SWEEP, rsp_count - rsp0);
      end
      end_test("4 random sweep", err0);

      // reset in the middle of a refill
      err0   = err_count;
      addr_a = 16'h0230;
      addr_b = 16'h0D40;
      issue_read(addr_a, stalls);
      req_valid_i = 1'b0;
      wait_drain();
      issue_read(addr_b, stalls);
      req_valid_i = 1'b0;
      n = 0;
      @(negedge clk_i);
      while (!be_valid_o) begin
         n++;
         if (n > WAIT_LIMIT) begin
            abort_wait("refill start");
         end
         @(negedge clk_i);
      end
      @(posedge clk_i);
      #1;
      apply_reset();
      @(negedge clk_i);
      check_count += 3;
      if (be_valid_o !== 1'b0) begin
         err_count++;
         $display("Fail at %0t: be_valid_o expected 0 got %b", $time, be_valid_o);
      end
      if (rsp_valid_o !== 1'b0) begin
         err_count++;
         $display("Fail at %0t: rsp_valid_o expected 0 got %b", $time, rsp_valid_o);
      end
      if (req_ready_o !== 1'b1) begin
         err_count++;
         $display("Fail at %0t: req_ready_o expected 1 got %b", $time, req_ready_o);
      end
      @(posedge clk_i);
      #1;
      beats0 = beat_count;
      issue_read(addr_a, stalls);
      req_valid_i = 1'b0;
      wait_drain();
      check_count++;
      if (beat_count - beats0 != LINE_WORDS) begin
         err_count++;
         $display("Fail at %0t: be_ack_i beats expected %0d got %0d",
                  $time, LINE_WORDS, beat_count - beats0);
      end
      end_test("5 reset", err0);

      finish_run();
   end

endmodule

//--- tb.f
source/cache_pkg.sv
source/refill_if.sv
source/cache_array.sv
source/line_refill.sv
source/cache_ctrl.sv
source/icache_top.sv
tests/icache_chk.sv
tests/icache_tb.sv
